// ==== sfo_search_pkg.sv ====
//////////////////////////////////////////////////
// SFO header search shared definitions
// Widths, search constants and the records that
// travel between the search blocks
//////////////////////////////////////////////////
package sfo_search_pkg;

    localparam int CORR_WIDTH          = 24;
    localparam int CORR_METADATA_WIDTH = 8;
    localparam int RESAMPLE_INT_WIDTH  = 8;
    localparam int RESAMPLE_FRAC_WIDTH = 16;
    localparam int CFO_MAX_LOG2        = 4;
    localparam int CFO_LEN_LOG2_WIDTH  = 3;
    localparam int CORR_STREAM_WIDTH   = 32;
    localparam int GLOBAL_SEARCH_LEN   = 4;

    // Room for the SFO index inside the peak record, enough for 256 correlators
    localparam int SFO_IDX_WIDTH       = 8;

    typedef struct packed {
        logic [CORR_WIDTH-1:0]          corr;
        logic [CORR_METADATA_WIDTH-1:0] metadata;
    } corr_item_t;

    typedef struct packed {
        logic [RESAMPLE_INT_WIDTH-1:0]  n1;
        logic [RESAMPLE_FRAC_WIDTH-1:0] n2;
    } resample_t;

    typedef struct packed {
        logic [CORR_WIDTH-1:0]          corr;
        logic [CORR_METADATA_WIDTH-1:0] metadata;
        resample_t                      resample;
        logic [CFO_MAX_LOG2-1:0]        cfo_idx;
    } assignment_t;

    // Best masked correlator result of the current search
    typedef struct packed {
        corr_item_t                item;
        logic [SFO_IDX_WIDTH-1:0]  sfo_idx;
        logic [CFO_MAX_LOG2-1:0]   cfo_idx;
    } peak_t;

endpackage

// ==== cfo_index_seq.sv ====
//////////////////////////////////////////////////
// CFO index sequencer
// Walks the CFO bins in bit-reversed order and gives
// the natural index, its mask bit and the last bin
//////////////////////////////////////////////////
module cfo_index_seq (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           i_reset,
    input  logic                                           i_incr,
    input  logic [sfo_search_pkg::CFO_LEN_LOG2_WIDTH-1:0]  i_len_log2,
    input  logic [2**sfo_search_pkg::CFO_MAX_LOG2-1:0]     i_mask,
    output logic [sfo_search_pkg::CFO_MAX_LOG2-1:0]        o_cfo_idx,
    output logic                                           o_mask_bit,
    output logic                                           o_last
);
    localparam int MAX_LOG2 = sfo_search_pkg::CFO_MAX_LOG2;
    localparam int LEN_W    = sfo_search_pkg::CFO_LEN_LOG2_WIDTH;
    localparam int MAX_BINS = 2 ** MAX_LOG2;

    logic [MAX_LOG2-1:0] count_q;
    logic [LEN_W-1:0]    len_q;
    logic [MAX_BINS-1:0] mask_q;
    logic [MAX_BINS-1:0] mask_visit;
    logic [MAX_LOG2:0]   num_bins;

    // Bit-reverse the count over the full width, then drop the unused low bits
    function automatic logic [MAX_LOG2-1:0] to_natural(
        input logic [MAX_LOG2-1:0] count,
        input logic [LEN_W-1:0]    len_log2
    );
        logic [MAX_LOG2-1:0] rev;
        for (int b = 0; b < MAX_LOG2; b++) begin
            rev[b] = count[MAX_LOG2-1-b];
        end
        return rev >> (LEN_W'(MAX_LOG2) - len_log2);
    endfunction

    // The mask is indexed by natural bin, so put it in visiting order
    // before latching. Rotation then always presents the current bit at 0
    always_comb begin
        for (int k = 0; k < MAX_BINS; k++) begin
            mask_visit[k] = i_mask[to_natural(MAX_LOG2'(k), i_len_log2)];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
            len_q   <= '0;
            mask_q  <= '0;
        end else if (i_reset) begin
            count_q <= '0;
            len_q   <= i_len_log2;
            mask_q  <= mask_visit;
        end else if (i_incr) begin
            count_q <= count_q + 1'b1;
            mask_q  <= {mask_q[0], mask_q[MAX_BINS-1:1]};
        end
    end

    assign num_bins   = (MAX_LOG2 + 1)'(1) << len_q;
    assign o_cfo_idx  = to_natural(count_q, len_q);
    assign o_mask_bit = mask_q[0];
    assign o_last     = ({1'b0, count_q} == num_bins - 1'b1);

endmodule

// ==== corr_shift_out.sv ====
//////////////////////////////////////////////////
// Correlator vector shift-out
// Holds one vector of correlator results and
// presents it one entry per advance
//////////////////////////////////////////////////
module corr_shift_out #(
    parameter int NUM_CORRELATORS = 4
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             i_load,
    input  logic                                             i_advance,
    input  sfo_search_pkg::corr_item_t [NUM_CORRELATORS-1:0] i_vec,
    output sfo_search_pkg::corr_item_t                       o_item,
    output logic [$clog2(NUM_CORRELATORS)-1:0]               o_sfo_idx,
    output logic                                             o_last
);
    localparam int SFO_W = $clog2(NUM_CORRELATORS);

    sfo_search_pkg::corr_item_t [NUM_CORRELATORS-1:0] vec_q;
    logic [SFO_W-1:0]                                 count_q;

    // Vector storage, entry 0 is always the one on the stream
    always_ff @(posedge clk) begin
        if (i_load) begin
            vec_q <= i_vec;
        end else if (i_advance) begin
            vec_q[NUM_CORRELATORS-2:0] <= vec_q[NUM_CORRELATORS-1:1];
        end
    end

    // Index of the correlator currently at entry 0
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (i_load) begin
            count_q <= '0;
        end else if (i_advance) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign o_item    = vec_q[0];
    assign o_sfo_idx = count_q;
    assign o_last    = (count_q == SFO_W'(NUM_CORRELATORS - 1));

endmodule

// ==== peak_tracker.sv ====
//////////////////////////////////////////////////
// Peak tracker
// Keeps the masked peak of a search, the global
// round count and best peak, and decides a hit
//////////////////////////////////////////////////
module peak_tracker #(
    parameter int NUM_CORRELATORS = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      i_clear,
    input  logic                                      i_round_reset,
    input  logic                                      i_sample,
    input  sfo_search_pkg::corr_item_t                i_item,
    input  logic [$clog2(NUM_CORRELATORS)-1:0]        i_sfo_idx,
    input  logic [sfo_search_pkg::CFO_MAX_LOG2-1:0]   i_cfo_idx,
    input  logic                                      i_mask_bit,
    input  logic                                      i_search_end,
    input  logic [sfo_search_pkg::CORR_WIDTH-1:0]     i_threshold,
    output logic                                      o_hit,
    output sfo_search_pkg::peak_t                     o_peak
);
    localparam int ROUND_LEN = sfo_search_pkg::GLOBAL_SEARCH_LEN;
    localparam int ROUND_W   = $clog2(ROUND_LEN + 1);

    sfo_search_pkg::peak_t                     peak_q;
    logic [ROUND_W-1:0]                        round_q;
    logic [sfo_search_pkg::CORR_WIDTH-1:0]     best_q;
    logic                                      take;

    // Strictly greater, so the first of equal values is kept
    assign take = i_sample && i_mask_bit && (i_item.corr > peak_q.item.corr);

    always_ff @(posedge clk) begin
        if (rst) begin
            peak_q  <= '0;
            round_q <= '0;
            best_q  <= '0;
        end else begin
            if (i_clear) begin
                peak_q <= '0;
                if (i_round_reset) begin
                    round_q <= '0;
                    best_q  <= '0;
                end
            end else if (take) begin
                peak_q.item    <= i_item;
                peak_q.sfo_idx <= sfo_search_pkg::SFO_IDX_WIDTH'(i_sfo_idx);
                peak_q.cfo_idx <= i_cfo_idx;
            end
            // The round stops counting once it is used up
            if (i_search_end && (round_q < ROUND_W'(ROUND_LEN))) begin
                round_q <= round_q + 1'b1;
                if (peak_q.item.corr > best_q) begin
                    best_q <= peak_q.item.corr;
                end
            end
        end
    end

    // First search of a round uses the threshold, later ones the round's best
    always_comb begin
        if (round_q == '0) begin
            o_hit = (peak_q.item.corr > i_threshold);
        end else if (round_q < ROUND_W'(ROUND_LEN)) begin
            o_hit = (peak_q.item.corr > best_q);
        end else begin
            o_hit = 1'b0;
        end
    end

    assign o_peak = peak_q;

endmodule

// ==== pathway_assign.sv ====
//////////////////////////////////////////////////
// Decode pathway assignment
// Stores each winning peak with its resampler
// pair into the next pathway, round robin
//////////////////////////////////////////////////
module pathway_assign #(
    parameter int NUM_CORRELATORS = 4,
    parameter int NUM_PATHWAYS    = 2
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                                              i_store,
    input  sfo_search_pkg::peak_t                             i_peak,
    input  sfo_search_pkg::resample_t [NUM_CORRELATORS-1:0]   i_resample_table,
    output sfo_search_pkg::assignment_t [NUM_PATHWAYS-1:0]    o_assignments,
    output logic [NUM_PATHWAYS-1:0]                           o_pathway_reset
);
    localparam int SFO_W  = $clog2(NUM_CORRELATORS);
    localparam int SLOT_W = $clog2(NUM_PATHWAYS);

    sfo_search_pkg::assignment_t [NUM_PATHWAYS-1:0] assign_q;
    sfo_search_pkg::assignment_t                    new_entry;
    logic [SLOT_W-1:0]                              slot_q;

    // The winning SFO selects its resampler pair from the table
    always_comb begin
        new_entry.corr     = i_peak.item.corr;
        new_entry.metadata = i_peak.item.metadata;
        new_entry.resample = i_resample_table[i_peak.sfo_idx[SFO_W-1:0]];
        new_entry.cfo_idx  = i_peak.cfo_idx;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            assign_q <= '0;
            slot_q   <= '0;
        end else if (i_store) begin
            assign_q[slot_q] <= new_entry;
            if (slot_q == SLOT_W'(NUM_PATHWAYS - 1)) begin
                slot_q <= '0;
            end else begin
                slot_q <= slot_q + 1'b1;
            end
        end
    end

    // Pathway being taken over gets its reset in the store cycle
    always_comb begin
        o_pathway_reset = '0;
        if (i_store) begin
            o_pathway_reset[slot_q] = 1'b1;
        end
    end

    assign o_assignments = assign_q;

endmodule

// ==== search_ctrl.sv ====
//////////////////////////////////////////////////
// SFO search controller
// FSM that runs one search: vector wait, shift-out
// per CFO bin, then the hit decision
//////////////////////////////////////////////////
module search_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic i_trigger_search,
    input  logic i_currently_decoding,
    input  logic i_corr_valid,
    input  logic i_corr_tready,
    input  logic i_cfo_last,
    input  logic i_shift_last,
    input  logic i_hit,
    output logic o_seq_reset,
    output logic o_seq_incr,
    output logic o_load,
    output logic o_advance,
    output logic o_clear,
    output logic o_round_reset,
    output logic o_sample,
    output logic o_search_end,
    output logic o_store,
    output logic o_corr_tvalid,
    output logic o_search_done,
    output logic o_search_hit
);
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_VEC_WAIT,
        ST_SHIFT,
        ST_CFO_STEP,
        ST_DECIDE
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   xfer;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign xfer = (state_q == ST_SHIFT) && i_corr_tready;

    always_comb begin
        state_d       = state_q;
        o_seq_reset   = 1'b0;
        o_seq_incr    = 1'b0;
        o_load        = 1'b0;
        o_clear       = 1'b0;
        o_round_reset = 1'b0;
        o_search_end  = 1'b0;
        o_store       = 1'b0;
        o_search_done = 1'b0;
        o_search_hit  = 1'b0;
        case (state_q)
            ST_IDLE: begin
                // Settings are latched and the tracker cleared with the trigger
                if (i_trigger_search) begin
                    o_seq_reset   = 1'b1;
                    o_clear       = 1'b1;
                    o_round_reset = ~i_currently_decoding;
                    state_d       = ST_VEC_WAIT;
                end
            end
            ST_VEC_WAIT: begin
                if (i_corr_valid) begin
                    o_load  = 1'b1;
                    state_d = ST_SHIFT;
                end
            end
            ST_SHIFT: begin
                if (xfer && i_shift_last) begin
                    state_d = ST_CFO_STEP;
                end
            end
            ST_CFO_STEP: begin
                if (i_cfo_last) begin
                    state_d = ST_DECIDE;
                end else begin
                    o_seq_incr = 1'b1;
                    state_d    = ST_VEC_WAIT;
                end
            end
            ST_DECIDE: begin
                o_search_end  = 1'b1;
                o_search_done = 1'b1;
                o_search_hit  = i_hit;
                o_store       = i_hit;
                state_d       = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // Every accepted word is both compared and shifted away
    assign o_corr_tvalid = (state_q == ST_SHIFT);
    assign o_sample      = xfer;
    assign o_advance     = xfer;

endmodule

// ==== sfo_header_search.sv ====
//////////////////////////////////////////////////
// SFO header search top level
// Scans all CFO bins, streams the correlator
// results and assigns hits to decode pathways
//////////////////////////////////////////////////
module sfo_header_search #(
    parameter int NUM_CORRELATORS = 4,
    parameter int NUM_PATHWAYS    = 2
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                i_trigger_search,
    input  logic                                                i_currently_decoding,
    input  logic                                                i_corr_valid,
    input  sfo_search_pkg::corr_item_t [NUM_CORRELATORS-1:0]    i_corr_vec,
    input  logic [sfo_search_pkg::CFO_LEN_LOG2_WIDTH-1:0]       i_cfo_len_log2,
    input  logic [2**sfo_search_pkg::CFO_MAX_LOG2-1:0]          i_cfo_mask,
    input  logic [sfo_search_pkg::CORR_WIDTH-1:0]               i_threshold,
    input  sfo_search_pkg::resample_t [NUM_CORRELATORS-1:0]     i_resample_table,
    input  logic                                                i_corr_tready,
    output logic [sfo_search_pkg::CORR_STREAM_WIDTH-1:0]        o_corr_tdata,
    output logic                                                o_corr_tvalid,
    output logic                                                o_corr_tlast,
    output logic                                                o_search_done,
    output logic                                                o_search_hit,
    output logic [NUM_PATHWAYS-1:0]                             o_pathway_reset,
    output sfo_search_pkg::assignment_t [NUM_PATHWAYS-1:0]      o_assignments
);
    localparam int STREAM_W = sfo_search_pkg::CORR_STREAM_WIDTH;

    logic seq_reset, seq_incr, load, advance;
    logic clear, round_reset, sample, search_end, store;
    logic cfo_last, mask_bit, shift_last, hit;
    logic [sfo_search_pkg::CFO_MAX_LOG2-1:0] cfo_idx;
    logic [$clog2(NUM_CORRELATORS)-1:0]      sfo_idx;
    sfo_search_pkg::corr_item_t              cur_item;
    sfo_search_pkg::peak_t                   peak;

    search_ctrl u_ctrl (
        .clk, .rst, .i_trigger_search, .i_currently_decoding, .i_corr_valid, .i_corr_tready,
        .i_cfo_last(cfo_last), .i_shift_last(shift_last), .i_hit(hit),
        .o_seq_reset(seq_reset), .o_seq_incr(seq_incr), .o_load(load), .o_advance(advance),
        .o_clear(clear), .o_round_reset(round_reset), .o_sample(sample),
        .o_search_end(search_end), .o_store(store), .o_corr_tvalid,
        .o_search_done, .o_search_hit
    );

    cfo_index_seq u_seq (
        .clk, .rst, .i_reset(seq_reset), .i_incr(seq_incr), .i_len_log2(i_cfo_len_log2),
        .i_mask(i_cfo_mask), .o_cfo_idx(cfo_idx), .o_mask_bit(mask_bit), .o_last(cfo_last)
    );

    corr_shift_out #(.NUM_CORRELATORS(NUM_CORRELATORS)) u_shift (
        .clk, .rst, .i_load(load), .i_advance(advance), .i_vec(i_corr_vec),
        .o_item(cur_item), .o_sfo_idx(sfo_idx), .o_last(shift_last)
    );

    peak_tracker #(.NUM_CORRELATORS(NUM_CORRELATORS)) u_peak (
        .clk, .rst, .i_clear(clear), .i_round_reset(round_reset), .i_sample(sample),
        .i_item(cur_item), .i_sfo_idx(sfo_idx), .i_cfo_idx(cfo_idx), .i_mask_bit(mask_bit),
        .i_search_end(search_end), .i_threshold, .o_hit(hit), .o_peak(peak)
    );

    pathway_assign #(.NUM_CORRELATORS(NUM_CORRELATORS), .NUM_PATHWAYS(NUM_PATHWAYS)) u_assign (
        .clk, .rst, .i_store(store), .i_peak(peak), .i_resample_table,
        .o_assignments, .o_pathway_reset
    );

    // Top bit flags the first natural CFO bin
    assign o_corr_tdata = {(cfo_idx == '0), (STREAM_W - 1)'(cur_item.corr)};
    assign o_corr_tlast = shift_last;

endmodule

// ==== sfo_search_assertions.sv ====
//////////////////////////////////////////////////
// SFO header search protocol assertions
// Stream stability and result pulse rules
//////////////////////////////////////////////////
module sfo_search_assertions #(
    parameter int NUM_PATHWAYS = 2
) (
    input logic                    clk,
    input logic                    rst,
    input logic [31:0]             o_corr_tdata,
    input logic                    o_corr_tvalid,
    input logic                    o_corr_tlast,
    input logic                    i_corr_tready,
    input logic                    o_search_done,
    input logic                    o_search_hit,
    input logic [NUM_PATHWAYS-1:0] o_pathway_reset
);
    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed assertions
    int fail_count;

    // A stalled word stays on the stream until it is taken
    stream_hold: assert property (@(posedge clk) disable iff (rst)
        (o_corr_tvalid && !i_corr_tready) |=>
        (o_corr_tvalid && $stable(o_corr_tdata) && $stable(o_corr_tlast)))
        else begin
            $error("Stream word changed while stalled");
            fail_count++;
        end

    reset_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(o_pathway_reset))
        else begin
            $error("Pathway reset is not one-hot");
            fail_count++;
        end

    reset_with_done: assert property (@(posedge clk) disable iff (rst)
        (o_pathway_reset != '0) |-> o_search_done)
        else begin
            $error("Pathway reset outside the done cycle");
            fail_count++;
        end

    hit_with_done: assert property (@(posedge clk) disable iff (rst)
        o_search_hit |-> o_search_done)
        else begin
            $error("Search hit outside the done cycle");
            fail_count++;
        end

endmodule

bind sfo_header_search sfo_search_assertions #(.NUM_PATHWAYS(NUM_PATHWAYS)) u_assertions (
    .clk(clk), .rst(rst), .o_corr_tdata(o_corr_tdata), .o_corr_tvalid(o_corr_tvalid),
    .o_corr_tlast(o_corr_tlast), .i_corr_tready(i_corr_tready),
    .o_search_done(o_search_done), .o_search_hit(o_search_hit),
    .o_pathway_reset(o_pathway_reset)
);

// ==== tb_sfo_header_search.sv ====
//////////////////////////////////////////////////
// SFO header search testbench
// Directed searches checked against a reference
// model of stream, peak, round rule and pathways
//////////////////////////////////////////////////
module tb_sfo_header_search;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NC          = 4;
    localparam int NP          = 2;
    localparam int CLK_PERIOD  = 4;
    localparam int ROUND_LEN   = sfo_search_pkg::GLOBAL_SEARCH_LEN;
    // 60 bins over 13 searches, plus room for the stalled back-pressure run
    localparam int EXP_CYCLES  = 60 * (NC + 3) + 13 * 6 + 16 * NC + 10;

    logic                                   clk;
    logic                                   rst;
    logic                                   i_trigger_search;
    logic                                   i_currently_decoding;
    logic                                   i_corr_valid;
    sfo_search_pkg::corr_item_t [NC-1:0]    i_corr_vec;
    logic [2:0]                             i_cfo_len_log2;
    logic [15:0]                            i_cfo_mask;
    logic [23:0]                            i_threshold;
    sfo_search_pkg::resample_t [NC-1:0]     i_resample_table;
    logic                                   i_corr_tready;
    logic [31:0]                            o_corr_tdata;
    logic                                   o_corr_tvalid;
    logic                                   o_corr_tlast;
    logic                                   o_search_done;
    logic                                   o_search_hit;
    logic [NP-1:0]                          o_pathway_reset;
    sfo_search_pkg::assignment_t [NP-1:0]   o_assignments;

    logic [31:0]                            lfsr;
    sfo_search_pkg::corr_item_t [NC-1:0]    bins_mem [16];
    sfo_search_pkg::assignment_t [NP-1:0]   exp_assign;
    logic [31:0]                            got_words [$];
    logic [31:0]                            ref_words [$];
    string                                  test_name;
    int                                     round_cnt;
    logic [23:0]                            round_best;
    int                                     slot;

    sfo_header_search #(.NUM_CORRELATORS(NC), .NUM_PATHWAYS(NP)) DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int bit_reverse(input int value, input int width);
        int r;
        r = 0;
        for (int b = 0; b < width; b++) begin
            r = (r << 1) | ((value >> b) & 1);
        end
        return r;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            stop_with_failure($sformatf("FAIL %s %s: expected %h, actual %h",
                                        test_name, what, exp, act));
        end
    endtask

    // Fill the bins with random results, all sharing one top nibble
    task automatic gen_vectors(input int nbins, input logic [3:0] top);
        logic [31:0] r;
        for (int b = 0; b < nbins; b++) begin
            for (int k = 0; k < NC; k++) begin
                r = rand_bits(20);
                bins_mem[b][k].corr = {top, r[19:0]};
                r = rand_bits(8);
                bins_mem[b][k].metadata = r[7:0];
            end
        end
    endtask

    task automatic run_search(input logic dec, input int len_log2, input logic [15:0] mask,
                              input logic [23:0] thr, input logic bp);
        int                          nbins;
        int                          nat;
        int                          k;
        int                          waited;
        int                          pk_sfo;
        int                          pk_cfo;
        logic                        last_seen;
        logic                        exp_hit;
        logic [NP-1:0]               exp_reset;
        logic [31:0]                 exp_word;
        sfo_search_pkg::corr_item_t  pk;
        nbins = 1 << len_log2;
        pk = '0;
        pk_sfo = 0;
        pk_cfo = 0;
        // Masked peak in visiting order, the first of equal values stays
        for (int c = 0; c < nbins; c++) begin
            nat = bit_reverse(c, len_log2);
            for (int j = 0; j < NC; j++) begin
                if (mask[nat] && bins_mem[nat][j].corr > pk.corr) begin
                    pk = bins_mem[nat][j];
                    pk_sfo = j;
                    pk_cfo = nat;
                end
            end
        end
        if (!dec) begin
            round_cnt = 0;
            round_best = '0;
        end
        if (round_cnt == 0) begin
            exp_hit = (pk.corr > thr);
        end else if (round_cnt < ROUND_LEN) begin
            exp_hit = (pk.corr > round_best);
        end else begin
            exp_hit = 1'b0;
        end
        if (round_cnt < ROUND_LEN) begin
            round_cnt++;
            if (pk.corr > round_best) begin
                round_best = pk.corr;
            end
        end
        exp_reset = '0;
        if (exp_hit) begin
            exp_assign[slot].corr = pk.corr;
            exp_assign[slot].metadata = pk.metadata;
            exp_assign[slot].resample = i_resample_table[pk_sfo];
            exp_assign[slot].cfo_idx = 4'(pk_cfo);
            exp_reset[slot] = 1'b1;
            slot = (slot + 1) % NP;
        end

        got_words.delete();
        @(posedge clk);
        i_trigger_search <= 1'b1;
        i_currently_decoding <= dec;
        i_cfo_len_log2 <= 3'(len_log2);
        i_cfo_mask <= mask;
        i_threshold <= thr;
        i_corr_tready <= 1'b1;
        for (int c = 0; c < nbins; c++) begin
            nat = bit_reverse(c, len_log2);
            @(posedge clk);
            i_trigger_search <= 1'b0;
            i_corr_valid <= 1'b1;
            i_corr_vec <= bins_mem[nat];
            @(posedge clk);
            i_corr_valid <= 1'b0;
            k = 0;
            last_seen = 1'b0;
            while (!last_seen) begin
                @(negedge clk);
                if (o_corr_tvalid && i_corr_tready) begin
                    exp_word = {(nat == 0), 7'd0, bins_mem[nat][k].corr};
                    check($sformatf("word cfo %0d sfo %0d", nat, k), exp_word, o_corr_tdata);
                    check($sformatf("tlast cfo %0d sfo %0d", nat, k), (k == NC - 1),
                          o_corr_tlast);
                    got_words.push_back(o_corr_tdata);
                    last_seen = o_corr_tlast;
                    k++;
                end
                @(posedge clk);
                i_corr_tready <= bp ? rand_bits(1) : 1'b1;
            end
        end

        waited = 0;
        last_seen = 1'b0;
        while (!last_seen) begin
            @(negedge clk);
            last_seen = o_search_done;
            waited++;
            if (!last_seen && waited > 8) begin
                stop_with_failure($sformatf("Search done pulse missing in test %s", test_name));
            end
        end
        check("hit", exp_hit, o_search_hit);
        check("pathway reset", exp_reset, o_pathway_reset);
        @(negedge clk);
        check("done width", 0, o_search_done);
        for (int p = 0; p < NP; p++) begin
            check($sformatf("assignment %0d", p), exp_assign[p], o_assignments[p]);
        end
    endtask

    task automatic stream_order_and_format();
        test_name = "stream_format";
        gen_vectors(4, rand_bits(4));
        run_search(1'b0, 2, 16'h000f, 24'hffffff, 1'b0);
        check("word count", 4 * NC, got_words.size());
    endtask

    task automatic threshold_decision();
        test_name = "threshold";
        gen_vectors(4, rand_bits(4));
        run_search(1'b0, 2, 16'h000f, 24'hffffff, 1'b0);
        // Random low bits under a fixed top nibble keep the peak above the threshold
        gen_vectors(4, 4'h9);
        run_search(1'b0, 2, 16'h000f, 24'h100000, 1'b0);
    endtask

    // The largest value sits in a masked-off bin, and two hits walk the slots
    task automatic mask_and_round_robin();
        test_name = "mask_round_robin";
        gen_vectors(4, 4'h5);
        bins_mem[1][2].corr = 24'hffffff;
        run_search(1'b0, 2, 16'h000d, 24'h100000, 1'b0);
        gen_vectors(4, 4'h7);
        bins_mem[3][0].corr = 24'hfffffe;
        run_search(1'b0, 2, 16'h0007, 24'h100000, 1'b0);
    endtask

    task automatic back_pressure_replay();
        test_name = "back_pressure";
        gen_vectors(8, rand_bits(4));
        run_search(1'b0, 3, 16'h00ff, 24'h100000, 1'b0);
        ref_words = got_words;
        run_search(1'b0, 3, 16'h00ff, 24'h100000, 1'b1);
        check("word count", ref_words.size(), got_words.size());
        for (int i = 0; i < ref_words.size(); i++) begin
            check($sformatf("stalled word %0d", i), ref_words[i], got_words[i]);
        end
    endtask

    task automatic global_round_rules();
        logic [3:0] tops [6];
        tops = '{4'h4, 4'h2, 4'h6, 4'h6, 4'hf, 4'h3};
        test_name = "global_round";
        for (int s = 0; s < 6; s++) begin
            gen_vectors(4, tops[s]);
            // Decoding stays high inside the round, the last trigger opens a new one
            run_search((s != 0) && (s != 5), 2, 16'h000f, 24'h100000, 1'b0);
        end
    endtask

    initial begin
        #(4 * EXP_CYCLES * CLK_PERIOD);
        stop_with_failure("Watchdog expired before the tests finished");
    end

    always @(negedge clk) begin
        if (DUT.u_assertions.fail_count != 0) begin
            stop_with_failure("A protocol assertion on the DUT outputs failed");
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        lfsr = 32'hf30a9f69;
        i_trigger_search = 1'b0;
        i_currently_decoding = 1'b0;
        i_corr_valid = 1'b0;
        i_corr_vec = '0;
        i_cfo_len_log2 = 3'd2;
        i_cfo_mask = '0;
        i_threshold = '0;
        i_corr_tready = 1'b1;
        exp_assign = '0;
        round_cnt = 0;
        round_best = '0;
        slot = 0;
        for (int k = 0; k < NC; k++) begin
            i_resample_table[k] = rand_bits(24);
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_name = "reset";
        check("tvalid", 0, o_corr_tvalid);
        check("done", 0, o_search_done);
        check("hit", 0, o_search_hit);
        check("pathway reset", 0, o_pathway_reset);
        for (int p = 0; p < NP; p++) begin
            check($sformatf("assignment %0d", p), 0, o_assignments[p]);
        end
        stream_order_and_format();
        threshold_decision();
        mask_and_round_robin();
        back_pressure_replay();
        global_round_rules();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== sfo_search.f ====
sfo_search_pkg.sv
cfo_index_seq.sv
corr_shift_out.sv
peak_tracker.sv
pathway_assign.sv
search_ctrl.sv
sfo_header_search.sv
sfo_search_assertions.sv
tb_sfo_header_search.sv
